/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_thread_controller
FILELIST  ?= thread_controller.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= TEST RESULT: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run fails unless the pass line shows up in the output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* dv/tb_thread_controller.sv */
`timescale 1ns/10ps
`include "ctrl_settings.svh"

module tb_thread_controller;

    localparam buf_pkg::addr_t OB_TBL [`THREADS] =
        '{`OB_BASE_0, `OB_BASE_1, `OB_BASE_2, `OB_BASE_3};
    localparam buf_pkg::addr_t WB_TBL [`THREADS] =
        '{`WB_BASE_0, `WB_BASE_1, `WB_BASE_2, `WB_BASE_3};

    logic                            clk_i;
    logic                            rst_ni;
    logic [`THREADS-1:0]             start_i;
    logic [`THREADS*`ITER_WIDTH-1:0] size_i;
    logic [`THREADS-1:0]             valid_o;
    buf_pkg::addr_t                  ib_addr_o;
    buf_pkg::addr_t                  ob_addr_o;
    buf_pkg::addr_t                  wb_w_addr_o;
    buf_pkg::addr_t                  wb_r_addr_o;
    buf_pkg::addr_t                  kb_addr_o;
    logic                            ob_wr_o;
    logic                            wb_wr_o;
    logic                            wb_sel_o;
    logic                            ex_sel_o;
    logic                            update_o;
    logic                            ml_clr_o;
    ctrl_pkg::phase_t                ib_sel_o;
    buf_pkg::lane_t                  ml_sel_o;

    ctrl_pkg::phase_t    phase_ref;
    logic [`THREADS-1:0] job_on;
    logic                quiet;
    int                  ob_cnt [`THREADS];
    int                  upd_cnt [`THREADS];
    int                  sel_cnt [`THREADS];
    int                  clr_cnt [`THREADS];
    buf_pkg::addr_t      ib_last [`THREADS];
    int                  sz [`THREADS];
    int                  errors;
    int                  timeouts;
    int                  jobs;

    thread_controller thread_controller_inst (.*);

    always #20 clk_i = ~clk_i;

    // ring position, 3 after reset and counting down
    always @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            phase_ref <= 2'd3;
        end else begin
            phase_ref <= phase_ref - 1'b1;
        end
    end

    task automatic mismatch(input string name, input int got, input int exp);
        errors++;
        $display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp);
    endtask

    task automatic problem(input string msg);
        errors++;
        $display("error: %s", msg);
    endtask

    // thread whose context sits in a given ring stage this cycle
    function automatic int stage_owner(input int stage);
        return (int'(phase_ref) + stage + 1) % `THREADS;
    endfunction

    assert property (@(negedge clk_i) disable iff (!rst_ni)
        quiet |-> (valid_o == '0 && !ob_wr_o && !wb_wr_o && !update_o && !ml_clr_o))
        else problem("outputs active before any start");

    assert property (@(negedge clk_i) disable iff (!rst_ni) (valid_o & ~job_on) == '0)
        else problem("valid raised on a thread with no job");

    always @(negedge clk_i) begin : monitor
        int t;
        buf_pkg::addr_t exp_addr;
        if (rst_ni) begin
            if (ob_wr_o) begin
                t = stage_owner(2);
                exp_addr = OB_TBL[t] + buf_pkg::addr_t'(ob_cnt[t]);
                assert (job_on[t]) else problem($sformatf("ob write for idle thread %0d", t));
                assert (ob_addr_o == exp_addr)
                    else mismatch("ob_addr_o", int'(ob_addr_o), int'(exp_addr));
                assert (ml_sel_o == buf_pkg::lane_t'(ob_cnt[t]))
                    else mismatch("ml_sel_o", int'(ml_sel_o), ob_cnt[t]);
                ob_cnt[t]++;
            end
            if (update_o) begin
                t = stage_owner(1);
                assert (job_on[t]) else problem($sformatf("update for idle thread %0d", t));
                upd_cnt[t]++;
            end
            if (ml_clr_o) begin
                t = stage_owner(1);
                assert (job_on[t] && ob_cnt[t] == 0 && upd_cnt[t] == 0)
                    else problem($sformatf("accumulator clear out of order on thread %0d", t));
                clr_cnt[t]++;
            end
            if (wb_sel_o || ex_sel_o) begin
                t = stage_owner(1);
                assert (wb_sel_o == ex_sel_o)
                    else mismatch("ex_sel_o", int'(ex_sel_o), int'(wb_sel_o));
                assert (job_on[t] && wb_wr_o)
                    else problem($sformatf("select raised outside a row pass on thread %0d", t));
                sel_cnt[t]++;
            end
            if (wb_wr_o) begin
                t = stage_owner(1);
                assert (wb_w_addr_o >= WB_TBL[t] && wb_w_addr_o <= WB_TBL[t] + 10'd63)
                    else mismatch("wb_w_addr_o", int'(wb_w_addr_o), int'(WB_TBL[t]));
            end
            if (!quiet) begin
                assert (ib_sel_o == ctrl_pkg::phase_t'(stage_owner(1)))
                    else mismatch("ib_sel_o", int'(ib_sel_o), stage_owner(1));
            end
            // read side addresses of the stage 0 context
            t = stage_owner(0);
            if (!quiet) begin
                assert (wb_r_addr_o >= WB_TBL[t] && wb_r_addr_o <= WB_TBL[t] + 10'd63)
                    else mismatch("wb_r_addr_o", int'(wb_r_addr_o), int'(WB_TBL[t]));
                assert (kb_addr_o <= buf_pkg::addr_t'(`ROW_LAST))
                    else mismatch("kb_addr_o", int'(kb_addr_o), `ROW_LAST);
                assert (ib_addr_o == '0 || ib_addr_o == ib_last[t] ||
                        ib_addr_o == ib_last[t] + 1'b1)
                    else mismatch("ib_addr_o", int'(ib_addr_o), int'(ib_last[t]));
            end
            ib_last[t] = ib_addr_o;
        end
    end

    task automatic run_job(input int t, input int s);
        int cycles;
        int target;
        target = 4 * (67 + 64 * s + `LANES);
        ob_cnt[t] = 0;
        upd_cnt[t] = 0;
        sel_cnt[t] = 0;
        clr_cnt[t] = 0;
        job_on[t] = 1'b1;
        @(posedge clk_i);
        size_i[t*`ITER_WIDTH +: `ITER_WIDTH] <= ctrl_pkg::iter_t'(s);
        start_i[t] <= 1'b1;
        cycles = 0;
        @(negedge clk_i);
        // latency counts from the first turn that sees the request
        while (phase_ref != ctrl_pkg::phase_t'(t) && cycles < `THREADS) begin
            @(negedge clk_i);
            cycles++;
        end
        cycles = 0;
        while (!valid_o[t] && cycles < target + 40) begin
            @(negedge clk_i);
            cycles++;
        end
        if (!valid_o[t]) begin
            timeouts++;
            $display("thread %0d never raised valid", t);
        end
        assert (cycles >= target - 4 && cycles <= target + 4)
            else mismatch("valid_o latency", cycles, target);
        // valid holds while the request stays up
        repeat (8) begin
            @(negedge clk_i);
            assert (valid_o[t]) else problem($sformatf("thread %0d valid dropped early", t));
        end
        @(posedge clk_i);
        start_i[t] <= 1'b0;
        cycles = 0;
        @(negedge clk_i);
        while (valid_o[t] && cycles < 16) begin
            @(negedge clk_i);
            cycles++;
        end
        if (valid_o[t]) begin
            timeouts++;
            $display("thread %0d kept valid after start dropped", t);
        end
        assert (cycles <= 8) else mismatch("valid_o fall delay", cycles, 8);
        assert (ob_cnt[t] == `LANES) else mismatch("ob_wr_o count", ob_cnt[t], `LANES);
        assert (upd_cnt[t] == s + 1) else mismatch("update_o count", upd_cnt[t], s + 1);
        assert (sel_cnt[t] == (s + 1) * (`ROW_LAST - `ACC_FIRST))
            else mismatch("wb_sel_o count", sel_cnt[t], (s + 1) * (`ROW_LAST - `ACC_FIRST));
        assert (clr_cnt[t] > 0)
            else problem($sformatf("thread %0d never cleared its accumulators", t));
        job_on[t] = 1'b0;
        jobs++;
    endtask

    initial begin
        clk_i = 1'b0;
        rst_ni = 1'b0;
        start_i = '0;
        size_i = '0;
        job_on = '0;
        quiet = 1'b1;
        errors = 0;
        timeouts = 0;
        jobs = 0;
        void'($urandom(32'hb0c0));
        repeat (3) @(posedge clk_i);
        rst_ni <= 1'b1;
        repeat (20) @(negedge clk_i);
        quiet = 1'b0;
        // one thread at a time
        for (int t = 0; t < `THREADS; t++) begin
            run_job(t, t % 3);
        end
        // all four in flight together
        for (int t = 0; t < `THREADS; t++) begin
            sz[t] = $urandom_range(2, 0);
        end
        fork
            run_job(0, sz[0]);
            run_job(1, sz[1]);
            run_job(2, sz[2]);
            run_job(3, sz[3]);
        join
        $display("jobs %0d, errors %0d, timeouts %0d", jobs, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* src/buf_pkg.sv */
`include "ctrl_settings.svh"

package buf_pkg;

    typedef logic [`ADDR_WIDTH-1:0] addr_t;

    // offset inside a 64-word row region
    typedef logic [$clog2(`ROW_LAST + 1)-1:0] row_ofs_t;

    typedef logic [$clog2(`LANES)-1:0] lane_t;

endpackage

/* src/context_ring.sv */
`timescale 1ns/10ps
`include "ctrl_settings.svh"

module context_ring (
    input  logic             clk_i,
    input  logic             rst_ni,
    input  ctrl_pkg::phase_t phase_i,
    thread_if.ring           slots [`THREADS],
    output buf_pkg::addr_t   ib_addr_o,
    output buf_pkg::addr_t   ob_addr_o,
    output buf_pkg::addr_t   wb_w_addr_o,
    output buf_pkg::addr_t   wb_r_addr_o,
    output buf_pkg::addr_t   kb_addr_o,
    output logic             ob_wr_o,
    output logic             wb_wr_o,
    output logic             wb_sel_o,
    output logic             ex_sel_o,
    output logic             update_o,
    output logic             ml_clr_o,
    output ctrl_pkg::phase_t ib_sel_o,
    output buf_pkg::lane_t   ml_sel_o
);

    ctrl_pkg::ctx_t  ctx_q [`THREADS];
    ctrl_pkg::ctx_t  cur;
    ctrl_pkg::ctx_t  nxt;
    logic [`THREADS-1:0] start_v;
    ctrl_pkg::iter_t size_v [`THREADS];
    logic            start_sel;
    ctrl_pkg::iter_t size_sel;
    logic            done_hit;
    logic            rel_hit;
    buf_pkg::lane_t  lane;

    function automatic buf_pkg::addr_t ob_base(ctrl_pkg::phase_t p);
        case (p)
            2'd0:    return `OB_BASE_0;
            2'd1:    return `OB_BASE_1;
            2'd2:    return `OB_BASE_2;
            default: return `OB_BASE_3;
        endcase
    endfunction

    function automatic buf_pkg::addr_t wb_base(ctrl_pkg::phase_t p);
        case (p)
            2'd0:    return `WB_BASE_0;
            2'd1:    return `WB_BASE_1;
            2'd2:    return `WB_BASE_2;
            default: return `WB_BASE_3;
        endcase
    endfunction

    // advance the offset, wrapping inside the 64-word region
    function automatic buf_pkg::addr_t row_next(buf_pkg::addr_t a);
        buf_pkg::row_ofs_t ofs;
        ofs = buf_pkg::row_ofs_t'(a) + 1'b1;
        return {a[`ADDR_WIDTH-1:$bits(buf_pkg::row_ofs_t)], ofs};
    endfunction

    // per-thread request lines, picked by phase
    for (genvar g = 0; g < `THREADS; g++) begin : g_slot
        assign start_v[g]     = slots[g].start;
        assign size_v[g]      = slots[g].size;
        assign slots[g].done  = done_hit && (phase_i == ctrl_pkg::phase_t'(g));
        assign slots[g].rel   = rel_hit && (phase_i == ctrl_pkg::phase_t'(g));
    end

    assign start_sel = start_v[phase_i];
    assign size_sel  = size_v[phase_i];

    assign cur  = ctx_q[`THREADS-1];
    assign lane = buf_pkg::lane_t'(cur.step);

    always_comb begin
        nxt        = cur;
        nxt.ob_wr  = 1'b0;
        nxt.wb_wr  = 1'b0;
        nxt.wb_sel = 1'b0;
        nxt.ex_sel = 1'b0;
        nxt.update = 1'b0;
        nxt.ml_clr = 1'b0;
        nxt.ml_sel = '0;
        done_hit   = 1'b0;
        rel_hit    = 1'b0;
        unique case (cur.state)
            ctrl_pkg::st_idle: begin
                nxt.passes    = size_sel;
                nxt.step      = '0;
                nxt.ib_addr   = '0;
                nxt.kb_addr   = '0;
                nxt.ob_addr   = ob_base(phase_i);
                nxt.wb_w_addr = wb_base(phase_i);
                nxt.wb_r_addr = wb_base(phase_i);
                nxt.ib_sel    = phase_i;
                if (start_sel) begin
                    nxt.state = ctrl_pkg::st_start;
                end
            end
            ctrl_pkg::st_start: begin
                // read pointers park on the last word so the first step wraps to 0
                nxt.state     = ctrl_pkg::st_clear;
                nxt.wb_r_addr = cur.wb_r_addr | buf_pkg::addr_t'(`ROW_LAST);
                nxt.kb_addr   = cur.kb_addr | buf_pkg::addr_t'(`ROW_LAST);
                nxt.wb_wr     = 1'b1;
                nxt.ml_clr    = 1'b1;
            end
            ctrl_pkg::st_clear, ctrl_pkg::st_update, ctrl_pkg::st_acc: begin
                nxt.wb_w_addr = row_next(cur.wb_w_addr);
                nxt.wb_r_addr = row_next(cur.wb_r_addr);
                nxt.kb_addr   = row_next(cur.kb_addr);
                nxt.ib_addr   = cur.ib_addr + 1'b1;
                nxt.step      = cur.step + 1'b1;
                nxt.wb_wr     = 1'b1;
                nxt.state     = ctrl_pkg::st_acc;
                if (cur.state == ctrl_pkg::st_clear) begin
                    nxt.ml_clr = 1'b1;
                end else if (cur.state == ctrl_pkg::st_update) begin
                    nxt.update = 1'b1;
                    nxt.passes = cur.passes - 1'b1;
                end else if (cur.step == ctrl_pkg::iter_t'(`ROW_LAST)) begin
                    if (cur.passes == '0) begin
                        nxt.state = ctrl_pkg::st_wb;
                    end else begin
                        nxt.state = ctrl_pkg::st_update;
                    end
                end else if (cur.step >= ctrl_pkg::iter_t'(`ACC_FIRST)) begin
                    // input word held while the tail of the row accumulates
                    nxt.ib_addr = cur.ib_addr;
                    nxt.wb_sel  = 1'b1;
                    nxt.ex_sel  = 1'b1;
                end
            end
            ctrl_pkg::st_wb: begin
                nxt.ob_wr   = 1'b1;
                nxt.ob_addr = {cur.ob_addr[`ADDR_WIDTH-1:$bits(buf_pkg::lane_t)], lane};
                nxt.ml_sel  = lane;
                nxt.update  = (cur.step == '0);
                nxt.step    = cur.step + 1'b1;
                if (cur.step == ctrl_pkg::iter_t'(`LANES - 1)) begin
                    nxt.state = ctrl_pkg::st_valid;
                    done_hit  = 1'b1;
                end
            end
            ctrl_pkg::st_valid: begin
                if (!start_sel) begin
                    nxt.state = ctrl_pkg::st_idle;
                    rel_hit   = 1'b1;
                end
            end
            default: begin
                nxt.state = ctrl_pkg::st_idle;
            end
        endcase
    end

    // stage 0 takes the new context, the rest shift along
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < `THREADS; i++) begin
                ctx_q[i] <= '0;
            end
        end else begin
            ctx_q[0] <= nxt;
            for (int i = 1; i < `THREADS; i++) begin
                ctx_q[i] <= ctx_q[i-1];
            end
        end
    end

    assign ib_addr_o   = ctx_q[0].ib_addr;
    assign wb_r_addr_o = ctx_q[0].wb_r_addr;
    assign kb_addr_o   = ctx_q[0].kb_addr;
    assign wb_w_addr_o = ctx_q[1].wb_w_addr;
    assign wb_wr_o     = ctx_q[1].wb_wr;
    assign wb_sel_o    = ctx_q[1].wb_sel;
    assign ex_sel_o    = ctx_q[1].ex_sel;
    assign update_o    = ctx_q[1].update;
    assign ml_clr_o    = ctx_q[1].ml_clr;
    assign ib_sel_o    = ctx_q[1].ib_sel;
    assign ob_addr_o   = ctx_q[2].ob_addr;
    assign ob_wr_o     = ctx_q[2].ob_wr;
    assign ml_sel_o    = ctx_q[2].ml_sel;

endmodule

/* src/ctrl_pkg.sv */
`include "ctrl_settings.svh"

package ctrl_pkg;

    typedef logic [$clog2(`THREADS)-1:0] phase_t;
    typedef logic [`ITER_WIDTH-1:0] iter_t;

    typedef enum logic [2:0] {
        st_idle,
        st_start,
        st_clear,
        st_acc,
        st_update,
        st_wb,
        st_valid
    } state_e;

    // one thread's context as it travels the ring
    typedef struct packed {
        state_e         state;
        iter_t          passes;
        iter_t          step;
        buf_pkg::addr_t ib_addr;
        buf_pkg::addr_t ob_addr;
        buf_pkg::addr_t wb_w_addr;
        buf_pkg::addr_t wb_r_addr;
        buf_pkg::addr_t kb_addr;
        phase_t         ib_sel;
        buf_pkg::lane_t ml_sel;
        logic           ob_wr;
        logic           wb_wr;
        logic           wb_sel;
        logic           ex_sel;
        logic           update;
        logic           ml_clr;
    } ctx_t;

endpackage

/* src/ctrl_settings.svh */
`ifndef CTRL_SETTINGS_SVH
`define CTRL_SETTINGS_SVH

// hardware threads, also the depth of the context ring
`define THREADS     4

`define ADDR_WIDTH  10
`define ITER_WIDTH  6

// one row pass is 64 steps, offsets 0..63
`define ROW_LAST    63
// first step with weight and execute select set
`define ACC_FIRST   15

// output lanes written back per job
`define LANES       8

// output buffer regions, 8-word aligned
`define OB_BASE_0   10'h200
`define OB_BASE_1   10'h208
`define OB_BASE_2   10'h210
`define OB_BASE_3   10'h218

// weight buffer regions, 64-word aligned
`define WB_BASE_0   10'h000
`define WB_BASE_1   10'h040
`define WB_BASE_2   10'h080
`define WB_BASE_3   10'h0c0

`endif

/* src/slot_scheduler.sv */
`timescale 1ns/10ps
`include "ctrl_settings.svh"

module slot_scheduler (
    input  logic             clk_i,
    input  logic             rst_ni,
    output ctrl_pkg::phase_t phase_o,
    thread_if.sched          slots [`THREADS]
);

    ctrl_pkg::phase_t phase_q;

    // counts down, so thread order is 3, 2, 1, 0
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            phase_q <= ctrl_pkg::phase_t'(`THREADS - 1);
        end else begin
            phase_q <= phase_q - 1'b1;
        end
    end

    assign phase_o = phase_q;

    for (genvar g = 0; g < `THREADS; g++) begin : g_turn
        assign slots[g].turn = (phase_q == ctrl_pkg::phase_t'(g));
    end

endmodule

/* src/thread_controller.sv */
`timescale 1ns/10ps
`include "ctrl_settings.svh"

module thread_controller (
    input  logic                            clk_i,
    input  logic                            rst_ni,
    input  logic [`THREADS-1:0]             start_i,
    input  logic [`THREADS*`ITER_WIDTH-1:0] size_i,
    output logic [`THREADS-1:0]             valid_o,
    output buf_pkg::addr_t                  ib_addr_o,
    output buf_pkg::addr_t                  ob_addr_o,
    output buf_pkg::addr_t                  wb_w_addr_o,
    output buf_pkg::addr_t                  wb_r_addr_o,
    output buf_pkg::addr_t                  kb_addr_o,
    output logic                            ob_wr_o,
    output logic                            wb_wr_o,
    output logic                            wb_sel_o,
    output logic                            ex_sel_o,
    output logic                            update_o,
    output logic                            ml_clr_o,
    output ctrl_pkg::phase_t                ib_sel_o,
    output buf_pkg::lane_t                  ml_sel_o
);

    ctrl_pkg::phase_t phase;

    thread_if thread_bus [`THREADS] ();

    slot_scheduler slot_scheduler_inst (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .phase_o (phase),
        .slots   (thread_bus)
    );

    for (genvar g = 0; g < `THREADS; g++) begin : g_thread
        thread_slot thread_slot_inst (
            .clk_i   (clk_i),
            .rst_ni  (rst_ni),
            .start_i (start_i[g]),
            .size_i  (size_i[g*`ITER_WIDTH +: `ITER_WIDTH]),
            .valid_o (valid_o[g]),
            .port    (thread_bus[g])
        );
    end

    context_ring context_ring_inst (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .phase_i     (phase),
        .slots       (thread_bus),
        .ib_addr_o   (ib_addr_o),
        .ob_addr_o   (ob_addr_o),
        .wb_w_addr_o (wb_w_addr_o),
        .wb_r_addr_o (wb_r_addr_o),
        .kb_addr_o   (kb_addr_o),
        .ob_wr_o     (ob_wr_o),
        .wb_wr_o     (wb_wr_o),
        .wb_sel_o    (wb_sel_o),
        .ex_sel_o    (ex_sel_o),
        .update_o    (update_o),
        .ml_clr_o    (ml_clr_o),
        .ib_sel_o    (ib_sel_o),
        .ml_sel_o    (ml_sel_o)
    );

endmodule

/* src/thread_if.sv */
`timescale 1ns/10ps
`include "ctrl_settings.svh"

interface thread_if;
    // turn strobe from the scheduler
    logic turn;
    // sampled request and size snapshot from the slot
    logic start;
    ctrl_pkg::iter_t size;
    // pulses from the ring
    logic done;
    logic rel;

    modport sched (output turn);
    modport slot (input turn, input done, input rel, output start, output size);
    modport ring (input start, input size, output done, output rel);
endinterface

/* src/thread_slot.sv */
`timescale 1ns/10ps
`include "ctrl_settings.svh"

module thread_slot (
    input  logic            clk_i,
    input  logic            rst_ni,
    input  logic            start_i,
    input  ctrl_pkg::iter_t size_i,
    output logic            valid_o,
    thread_if.slot          port
);

    logic            start_q;
    logic            valid_q;
    logic            busy;
    ctrl_pkg::iter_t size_q;

    assign busy = start_q | valid_q;

    // request is sampled once per turn, together with the size
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            start_q <= 1'b0;
            valid_q <= 1'b0;
        end else begin
            if (port.turn) begin
                start_q <= start_i;
            end
            if (port.done) begin
                valid_q <= 1'b1;
            end else if (port.rel) begin
                valid_q <= 1'b0;
            end
        end
    end

    // held while a job runs or its result is pending
    always_ff @(posedge clk_i) begin
        if (port.turn && !busy) begin
            size_q <= size_i;
        end
    end

    assign port.start = start_q;
    assign port.size  = size_q;
    assign valid_o    = valid_q;

endmodule

/* thread_controller.f */
+incdir+src
src/buf_pkg.sv
src/ctrl_pkg.sv
src/thread_if.sv
src/slot_scheduler.sv
src/thread_slot.sv
src/context_ring.sv
src/thread_controller.sv
dv/tb_thread_controller.sv
